/* hdl/mul_consts.svh */
`ifndef MUL_CONSTS_SVH
`define MUL_CONSTS_SVH

////////////////////////////////////////
// data widths
////////////////////////////////////////

`define MUL_XLEN 64
`define MUL_WLEN 32

////////////////////////////////////////
// instruction encodings
////////////////////////////////////////

`define MUL_OPC_OP        7'b0110011 // register-register ops.
`define MUL_OPC_OP32      7'b0111011 // 32-bit word ops.
`define MUL_FUNCT7_MULDIV 7'b0000001

`define MUL_F3_MUL    3'b000
`define MUL_F3_MULH   3'b001
`define MUL_F3_MULHSU 3'b010
`define MUL_F3_MULHU  3'b011

// one load cycle plus one per multiplier bit.
`define MUL_MAX_ITER 65

`endif

/* hdl/mul_pkg.sv */
`default_nettype none

`include "mul_consts.svh"

package mul_pkg;

    ////////////////////////////////////////
    // operation codes
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        OP_MUL    = 3'd0, // low half of signed product.
        OP_MULH   = 3'd1,
        OP_MULHSU = 3'd2,
        OP_MULHU  = 3'd3,
        OP_MULW   = 3'd4  // low word, sign extended.
    } mul_op_t;

    ////////////////////////////////////////
    // data words
    ////////////////////////////////////////

    typedef logic [`MUL_XLEN-1:0]   xlen_t;
    typedef logic [2*`MUL_XLEN-1:0] dxlen_t;
    typedef logic [31:0]            instr_t;

endpackage

`default_nettype wire

/* hdl/mul_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mul_consts.svh"

module mul_decode
    import mul_pkg::*;
(
    input  logic    start,
    input  instr_t  instr,
    output logic    mul_start,
    output logic    bad_instr,
    output mul_op_t op,
    output logic    op1_signed,
    output logic    op2_signed
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    ////////////////////////////////////////
    // operation select
    ////////////////////////////////////////

    always_comb begin
        op    = OP_MUL;
        legal = 1'b0;
        if (funct7 == `MUL_FUNCT7_MULDIV) begin
            if (opcode == `MUL_OPC_OP) begin
                legal = 1'b1;
                case (funct3)
                    `MUL_F3_MUL:    op = OP_MUL;
                    `MUL_F3_MULH:   op = OP_MULH;
                    `MUL_F3_MULHSU: op = OP_MULHSU;
                    `MUL_F3_MULHU:  op = OP_MULHU;
                    default:        legal = 1'b0; // divide ops live elsewhere.
                endcase
            end else if (opcode == `MUL_OPC_OP32 && funct3 == `MUL_F3_MUL) begin
                op    = OP_MULW;
                legal = 1'b1;
            end
        end
    end

    // rs2 is signed only for MUL and MULH.
    always_comb begin
        case (op)
            OP_MUL, OP_MULH: begin
                op1_signed = 1'b1;
                op2_signed = 1'b1;
            end
            OP_MULHSU: begin
                op1_signed = 1'b1;
                op2_signed = 1'b0;
            end
            default: begin
                op1_signed = 1'b0;
                op2_signed = 1'b0;
            end
        endcase
    end

    assign mul_start = start & legal;
    assign bad_instr = start & ~legal;

endmodule

`default_nettype wire

/* hdl/mul_shift_add.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mul_consts.svh"

module mul_shift_add
    import mul_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    mul_start,
    input  mul_op_t op,
    input  xlen_t   rs1_data,
    input  xlen_t   rs2_data,
    input  logic    op1_signed,
    input  logic    op2_signed,
    output logic    busy,
    output logic    fin,
    output mul_op_t fin_op,
    output logic    neg,
    output dxlen_t  product
);

    xlen_t   a_in;
    xlen_t   b_in;
    logic    a_neg;
    logic    b_neg;
    xlen_t   a_mag;
    xlen_t   b_mag;

    dxlen_t  mcand;
    xlen_t   mplier;
    dxlen_t  acc;
    logic    neg_q;
    mul_op_t op_q;

    ////////////////////////////////////////
    // operand magnitudes
    ////////////////////////////////////////

    always_comb begin
        if (op == OP_MULW) begin
            a_in  = {{(`MUL_XLEN-`MUL_WLEN){1'b0}}, rs1_data[`MUL_WLEN-1:0]};
            b_in  = {{(`MUL_XLEN-`MUL_WLEN){1'b0}}, rs2_data[`MUL_WLEN-1:0]};
            a_neg = 1'b0; // low word of the product is sign agnostic.
            b_neg = 1'b0;
        end else begin
            a_in  = rs1_data;
            b_in  = rs2_data;
            a_neg = op1_signed & rs1_data[`MUL_XLEN-1];
            b_neg = op2_signed & rs2_data[`MUL_XLEN-1];
        end
        a_mag = a_neg ? xlen_t'(-a_in) : a_in;
        b_mag = b_neg ? xlen_t'(-b_in) : b_in;
    end

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////

    // the loop ends as soon as no multiplier bits remain.
    assign fin = busy & ~(|mplier);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (mul_start) begin
            busy <= 1'b1;
        end else if (fin) begin
            busy <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // datapath
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (mul_start) begin
            mcand  <= {{`MUL_XLEN{1'b0}}, a_mag};
            mplier <= b_mag;
            acc    <= '0;
            neg_q  <= a_neg ^ b_neg; // sign the result block restores.
            op_q   <= op;
        end else if (busy && mplier != '0) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= {mcand[2*`MUL_XLEN-2:0], 1'b0};
            mplier <= {1'b0, mplier[`MUL_XLEN-1:1]};
        end
    end

    assign product = acc;
    assign neg     = neg_q;
    assign fin_op  = op_q;

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
        mul_start |-> !busy)
        else $error("start strobe arrived while the multiplier was busy.");

    a_fin_pulse: assert property (@(posedge clk) disable iff (reset)
        fin |=> !fin)
        else $error("fin held for more than one cycle.");

    a_busy_bound: assert property (@(posedge clk) disable iff (reset)
        $rose(busy) |-> ##[1:`MUL_MAX_ITER] !busy)
        else $error("multiply ran past its iteration bound.");

endmodule

`default_nettype wire

/* hdl/mul_result.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mul_consts.svh"

module mul_result
    import mul_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    fin,
    input  logic    bad_instr,
    input  mul_op_t fin_op,
    input  logic    neg,
    input  dxlen_t  product,
    output logic    done,
    output logic    illegal,
    output xlen_t   result
);

    dxlen_t signed_prod;
    xlen_t  sel;

    ////////////////////////////////////////
    // sign and half select
    ////////////////////////////////////////

    always_comb begin
        signed_prod = neg ? dxlen_t'(-product) : product;
        case (fin_op)
            OP_MUL: begin
                sel = signed_prod[`MUL_XLEN-1:0];
            end
            OP_MULH, OP_MULHSU, OP_MULHU: begin
                sel = signed_prod[2*`MUL_XLEN-1:`MUL_XLEN];
            end
            OP_MULW: begin
                sel = {{(`MUL_XLEN-`MUL_WLEN){signed_prod[`MUL_WLEN-1]}},
                       signed_prod[`MUL_WLEN-1:0]};
            end
            default: begin
                sel = '0;
            end
        endcase
    end

    ////////////////////////////////////////
    // output register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            done    <= 1'b0;
            illegal <= 1'b0;
        end else begin
            done    <= fin | bad_instr;
            illegal <= bad_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (bad_instr) begin
            result <= '0; // rejected instructions report zero.
        end else if (fin) begin
            result <= sel;
        end
    end

    // decode and execute finish on different cycles for one start.
    a_fin_bad_excl: assert property (@(posedge clk) disable iff (reset)
        !(fin && bad_instr))
        else $error("execute finish collided with an illegal instruction.");

endmodule

`default_nettype wire

/* hdl/mul_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module mul_unit
    import mul_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   start,
    input  instr_t instr,
    input  xlen_t  rs1_data,
    input  xlen_t  rs2_data,
    output logic   busy,
    output logic   done,
    output logic   illegal,
    output xlen_t  result
);

    ////////////////////////////////////////
    // internal wiring
    ////////////////////////////////////////

    logic    mul_start;
    logic    bad_instr;
    mul_op_t op;
    logic    op1_signed;
    logic    op2_signed;

    logic    fin;
    mul_op_t fin_op;
    logic    neg;
    dxlen_t  product;

    mul_decode decode_i (
        .start      (start),
        .instr      (instr),
        .mul_start  (mul_start),
        .bad_instr  (bad_instr),
        .op         (op),
        .op1_signed (op1_signed),
        .op2_signed (op2_signed)
    );

    mul_shift_add execute_i (
        .clk        (clk),
        .reset      (reset),
        .mul_start  (mul_start),
        .op         (op),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .op1_signed (op1_signed),
        .op2_signed (op2_signed),
        .busy       (busy),
        .fin        (fin),
        .fin_op     (fin_op),
        .neg        (neg),
        .product    (product)
    );

    mul_result result_i (
        .clk       (clk),
        .reset     (reset),
        .fin       (fin),
        .bad_instr (bad_instr),
        .fin_op    (fin_op),
        .neg       (neg),
        .product   (product),
        .done      (done),
        .illegal   (illegal),
        .result    (result)
    );

endmodule

`default_nettype wire

/* bench/mul_unit_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mul_consts.svh"

module mul_unit_tb
    import mul_pkg::*;
();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_FIXED    = 18;
    localparam int NUM_RANDOM   = 46;
    localparam int NUM_ROWS     = NUM_FIXED + NUM_RANDOM;
    localparam int DONE_LIMIT   = 70; // cycles allowed for one row.
    localparam int WATCHDOG_NS  = (NUM_ROWS * 70 + RESET_CYCLES) * CLK_PERIOD;

    typedef struct packed {
        instr_t instr;
        xlen_t  rs1;
        xlen_t  rs2;
        xlen_t  exp_result;
        logic   exp_illegal;
    } row_t;

    logic   clk;
    logic   reset;
    logic   start;
    instr_t instr;
    xlen_t  rs1_data;
    xlen_t  rs2_data;
    logic   busy;
    logic   done;
    logic   illegal;
    xlen_t  result;

    row_t rows [NUM_ROWS];
    int   err_count;
    int   pass_count;
    int   fail_count;
    int   done_count = 0;

    mul_unit dut_i (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .instr    (instr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .busy     (busy),
        .done     (done),
        .illegal  (illegal),
        .result   (result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // counts done cycles away from the rising edge.
    always @(negedge clk) begin
        if (done === 1'b1) begin
            done_count++;
        end
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic instr_t make_instr(logic [6:0] f7, logic [2:0] f3, logic [6:0] opc);
        return {f7, 5'd2, 5'd1, f3, 5'd3, opc}; // rs2 = x2, rs1 = x1, rd = x3.
    endfunction

    function automatic logic ref_illegal(instr_t ins);
        logic [2:0] f3;
        f3 = ins[14:12];
        if (ins[31:25] != `MUL_FUNCT7_MULDIV) begin
            return 1'b1;
        end
        if (ins[6:0] == `MUL_OPC_OP) begin
            return !(f3 == `MUL_F3_MUL || f3 == `MUL_F3_MULH ||
                     f3 == `MUL_F3_MULHSU || f3 == `MUL_F3_MULHU);
        end
        if (ins[6:0] == `MUL_OPC_OP32) begin
            return f3 != `MUL_F3_MUL;
        end
        return 1'b1;
    endfunction

    function automatic xlen_t ref_result(instr_t ins, xlen_t a, xlen_t b);
        logic [2:0]   f3;
        logic         signed_a;
        logic         signed_b;
        logic [127:0] ea;
        logic [127:0] eb;
        logic [127:0] prod;
        logic [63:0]  w;
        f3 = ins[14:12];
        if (ref_illegal(ins)) begin
            return '0;
        end
        if (ins[6:0] == `MUL_OPC_OP32) begin
            w = {32'h0, a[31:0]} * {32'h0, b[31:0]};
            return {{32{w[31]}}, w[31:0]};
        end
        signed_a = (f3 != `MUL_F3_MULHU);
        signed_b = (f3 == `MUL_F3_MUL) || (f3 == `MUL_F3_MULH);
        ea   = {{64{signed_a & a[63]}}, a};
        eb   = {{64{signed_b & b[63]}}, b};
        prod = ea * eb; // the low 128 bits are exact for two's complement.
        if (f3 == `MUL_F3_MUL) begin
            return prod[63:0];
        end
        return prod[127:64];
    endfunction

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////

    task automatic set_row(input int idx, input instr_t ins, input xlen_t a, input xlen_t b,
                           input xlen_t exp_res, input logic exp_ill);
        rows[idx] = '{instr: ins, rs1: a, rs2: b, exp_result: exp_res, exp_illegal: exp_ill};
    endtask

    task automatic build_table();
        instr_t i_mul;
        instr_t i_mulh;
        instr_t i_mulhsu;
        instr_t i_mulhu;
        instr_t i_mulw;
        instr_t ins;
        xlen_t  a;
        xlen_t  b;
        int     kind;
        i_mul    = make_instr(`MUL_FUNCT7_MULDIV, `MUL_F3_MUL, `MUL_OPC_OP);
        i_mulh   = make_instr(`MUL_FUNCT7_MULDIV, `MUL_F3_MULH, `MUL_OPC_OP);
        i_mulhsu = make_instr(`MUL_FUNCT7_MULDIV, `MUL_F3_MULHSU, `MUL_OPC_OP);
        i_mulhu  = make_instr(`MUL_FUNCT7_MULDIV, `MUL_F3_MULHU, `MUL_OPC_OP);
        i_mulw   = make_instr(`MUL_FUNCT7_MULDIV, `MUL_F3_MUL, `MUL_OPC_OP32);

        set_row(0, i_mul, 64'd3, 64'hFFFF_FFFF_FFFF_FFFB, 64'hFFFF_FFFF_FFFF_FFF1, 1'b0);
        set_row(1, i_mul, 64'hFFFF_FFFF_FFFF_FFF9, 64'hFFFF_FFFF_FFFF_FFFA, 64'd42, 1'b0);
        set_row(2, i_mul, 64'd0, 64'h1234_5678_9ABC_DEF0, 64'd0, 1'b0);
        set_row(3, i_mul, 64'h1234, 64'd0, 64'd0, 1'b0); // shortest latency.
        set_row(4, i_mul, 64'h8000_0000_0000_0000, '1, 64'h8000_0000_0000_0000, 1'b0);
        set_row(5, i_mulh, 64'h8000_0000_0000_0000, '1, 64'd0, 1'b0);
        set_row(6, i_mulh, '1, '1, 64'd0, 1'b0);
        set_row(7, i_mulhu, '1, '1, 64'hFFFF_FFFF_FFFF_FFFE, 1'b0);
        set_row(8, i_mulhsu, '1, '1, 64'hFFFF_FFFF_FFFF_FFFF, 1'b0);
        set_row(9, i_mulh, 64'h4000_0000_0000_0000, 64'd4, 64'd1, 1'b0);
        set_row(10, i_mulhsu, 64'hFFFF_FFFF_FFFF_FFFE, 64'h8000_0000_0000_0000,
                64'hFFFF_FFFF_FFFF_FFFF, 1'b0);
        set_row(11, i_mulhu, 64'h8000_0000_0000_0000, 64'd2, 64'd1, 1'b0);
        set_row(12, i_mulw, 64'hDEAD_BEEF_0000_0003, 64'h1234_5678_0000_0005, 64'hF, 1'b0);
        set_row(13, i_mulw, 64'h0000_0000_8000_0000, 64'hFFFF_FFFF_0000_0001,
                64'hFFFF_FFFF_8000_0000, 1'b0);
        set_row(14, i_mulw, 64'h0000_0001_0001_0000, 64'h0000_0000_0001_0000, 64'd0, 1'b0);
        set_row(15, make_instr(`MUL_FUNCT7_MULDIV, `MUL_F3_MULH, `MUL_OPC_OP32),
                64'd5, 64'd7, 64'd0, 1'b1);
        set_row(16, make_instr(7'b0000000, `MUL_F3_MUL, `MUL_OPC_OP), 64'd5, 64'd7, 64'd0, 1'b1);
        set_row(17, make_instr(`MUL_FUNCT7_MULDIV, 3'b100, `MUL_OPC_OP), 64'd5, 64'd7, 64'd0, 1'b1);

        for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
            kind = int'($urandom % 6);
            case (kind)
                0: ins = i_mul;
                1: ins = i_mulh;
                2: ins = i_mulhsu;
                3: ins = i_mulhu;
                4: ins = i_mulw;
                default: ins = make_instr(`MUL_FUNCT7_MULDIV, 3'($urandom % 7 + 1),
                                          `MUL_OPC_OP32);
            endcase
            a = {$urandom, $urandom};
            b = {$urandom, $urandom};
            if ($urandom % 4 == 0) begin
                b = b >> ($urandom % 64); // short multipliers end early.
            end
            set_row(i, ins, a, b, ref_result(ins, a, b), ref_illegal(ins));
        end
    endtask

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    task automatic compare_result(input xlen_t expected, input xlen_t actual);
        if (actual !== expected) begin
            $display("ERR %0t result expected %h got %h", $time, expected, actual);
            err_count++;
        end
    endtask

    task automatic compare_illegal(input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %0t illegal expected %b got %b", $time, expected, actual);
            err_count++;
        end
    endtask

    task automatic compare_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %b got %b", $time, name, expected, actual);
            err_count++;
        end
    endtask

    // inputs change 1 ns after the edge, outputs are sampled at the same point.
    task automatic run_row(input int idx);
        int wait_cycles;
        int errs_before;
        errs_before = err_count;
        while (busy) begin
            @(posedge clk);
            #1;
        end
        start    = 1'b1;
        instr    = rows[idx].instr;
        rs1_data = rows[idx].rs1;
        rs2_data = rows[idx].rs2;
        @(posedge clk);
        #1;
        start       = 1'b0;
        wait_cycles = 0;
        while (!done && wait_cycles < DONE_LIMIT) begin
            compare_flag("busy", 1'b1, busy);
            @(posedge clk);
            #1;
            wait_cycles++;
        end
        if (!done) begin
            $display("row %0d never signalled done within %0d cycles.", idx, DONE_LIMIT);
            err_count++;
        end else begin
            compare_result(rows[idx].exp_result, result);
            compare_illegal(rows[idx].exp_illegal, illegal);
            compare_flag("busy", 1'b0, busy);
            // each earlier row owns exactly one done cycle.
            if (done_count != idx) begin
                $display("row %0d saw %0d done cycles before it instead of %0d.",
                         idx, done_count, idx);
                err_count++;
            end
        end
        if (err_count == errs_before) begin
            pass_count++;
            $display("row %0d instr %h: ok, %0d cycles", idx, rows[idx].instr, wait_cycles);
        end else begin
            fail_count++;
            $display("row %0d instr %h: mismatch", idx, rows[idx].instr);
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        start      = 1'b0;
        instr      = '0;
        rs1_data   = '0;
        rs2_data   = '0;
        err_count  = 0;
        pass_count = 0;
        fail_count = 0;
        void'($urandom(32'h1905));
        build_table();

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        compare_flag("busy", 1'b0, busy);
        compare_flag("done", 1'b0, done);
        compare_flag("illegal", 1'b0, illegal);

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end

        @(posedge clk);
        #1;
        compare_flag("done", 1'b0, done);
        if (done_count != NUM_ROWS) begin
            $display("%0d done cycles seen for %0d starts.", done_count, NUM_ROWS);
            err_count++;
        end

        $display("rows passed: %0d, failed: %0d", pass_count, fail_count);
        if (err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all rows finished.");
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+hdl
hdl/mul_pkg.sv
hdl/mul_decode.sv
hdl/mul_shift_add.sv
hdl/mul_result.sv
hdl/mul_unit.sv
bench/mul_unit_tb.sv

/* Makefile */
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = mul_unit_tb
RTL_TOP    = mul_unit
FILELIST   = all.f
OBJDIR     = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "TEST PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
